// ==== src/adc_emu_pkg.sv ====
package adc_emu_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    localparam int num_slices  = 4;
    localparam int buf_depth   = 32;

    // abs input to magnitude
    localparam int noise_shift = 3;

    // nonzero lfsr seed for each slice
    localparam logic [3:0][15:0] noise_seeds = {
        16'h0a80,
        16'heb4b,
        16'hcc16,
        16'hace1
    };

    ////////////////////////////////////////
    // vector types
    ////////////////////////////////////////

    typedef logic [1:0]                     slice_id_t;
    typedef logic signed [11:0]             vin_t;
    typedef logic [7:0]                     mag_t;
    typedef logic [1:0]                     div_t;
    typedef logic [4:0]                     addr_t;
    // 0 .. buf_depth entries
    typedef logic [$clog2(buf_depth+1)-1:0] count_t;

    ////////////////////////////////////////
    // bundles
    ////////////////////////////////////////

    typedef struct packed {
        logic sign;
        mag_t mag;
    } adc_sample_t;

    typedef struct packed {
        slice_id_t   slice_id;
        adc_sample_t sample;
    } capture_entry_t;

    typedef struct packed {
        logic en_slice;
        div_t init;
    } slice_cfg_t;

endpackage

// ==== src/clk_edge_detect.sv ====
`timescale 1ns/10ps

module clk_edge_detect (
    input  logic emu_clk,
    input  logic arst_n,
    input  logic clk_in,
    output logic rise_pulse,
    output logic fall_pulse
);

    // previous clk_in seen on emu_clk
    logic clk_in_q;

    always_ff @(posedge emu_clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_in_q   <= 1'b0;
            rise_pulse <= 1'b0;
            fall_pulse <= 1'b0;
        end else begin
            clk_in_q   <= clk_in;
            rise_pulse <= clk_in & ~clk_in_q;
            fall_pulse <= ~clk_in & clk_in_q;
        end
    end

endmodule

// ==== src/slice_sync.sv ====
`timescale 1ns/10ps

module slice_sync (
    input  logic                   emu_clk,
    input  logic                   arst_n,
    input  logic                   rise_pulse,
    input  logic                   fall_pulse,
    input  adc_emu_pkg::slice_cfg_t cfg,
    input  logic                   alws_on,
    input  logic                   en_sync_in,
    output logic                   en_sync_out,
    output logic                   adder_clk
);

    import adc_emu_pkg::*;

    logic en_sync_sampled;
    logic en_sync;
    div_t div_cnt;

    ////////////////////////////////////////
    // enable chain
    ////////////////////////////////////////

    // sampled on falling clk_in, passed on at the rising one
    always_ff @(posedge emu_clk or negedge arst_n) begin
        if (!arst_n) begin
            en_sync_sampled <= 1'b0;
            en_sync_out     <= 1'b0;
        end else begin
            if (fall_pulse) begin
                en_sync_sampled <= en_sync_in;
            end
            if (rise_pulse) begin
                en_sync_out <= en_sync_sampled;
            end
        end
    end

    assign en_sync = en_sync_sampled & cfg.en_slice;

    ////////////////////////////////////////
    // phase divider
    ////////////////////////////////////////

    // init sets this slice's phase in the interleave
    always_ff @(posedge emu_clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (!en_sync) begin
            div_cnt <= cfg.init;
        end else if (alws_on) begin
            div_cnt <= 2'b11;
        end else if (fall_pulse) begin
            div_cnt <= div_cnt + div_t'(1);
        end
    end

    // rises on the 3 -> 0 wrap
    assign adder_clk = ~div_cnt[1];

endmodule

// ==== src/adc_quantizer.sv ====
`timescale 1ns/10ps

module adc_quantizer #(
    parameter logic [15:0] seed = 16'hace1
) (
    input  logic                    emu_clk,
    input  logic                    arst_n,
    input  logic                    adder_clk,
    input  adc_emu_pkg::vin_t       vin,
    input  logic                    noise_en,
    output logic                    sample_valid,
    output adc_emu_pkg::adc_sample_t sample
);

    import adc_emu_pkg::*;

    logic               adder_clk_q;
    logic               adder_rise;
    logic [15:0]        lfsr;
    logic               lfsr_fb;
    logic signed [3:0]  noise;
    logic signed [12:0] noise_ext;
    logic signed [12:0] vin_ext;
    logic signed [12:0] noisy;
    logic [12:0]        noisy_abs;
    logic [12:0]        mag_full;
    adc_sample_t        code;

    // adder_clk idles high out of reset, so start high to avoid a false edge
    always_ff @(posedge emu_clk or negedge arst_n) begin
        if (!arst_n) begin
            adder_clk_q <= 1'b1;
        end else begin
            adder_clk_q <= adder_clk;
        end
    end

    assign adder_rise = adder_clk & ~adder_clk_q;

    ////////////////////////////////////////
    // noise source
    ////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge emu_clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= seed;
        end else begin
            lfsr <= {lfsr[14:0], lfsr_fb};
        end
    end

    // -8 .. +7
    assign noise     = $signed(lfsr[3:0]);
    assign noise_ext = noise_en ? {{9{noise[3]}}, noise} : '0;

    ////////////////////////////////////////
    // sign / magnitude
    ////////////////////////////////////////

    assign vin_ext   = {vin[11], vin};
    assign noisy     = vin_ext + noise_ext;
    assign noisy_abs = noisy[12] ? 13'(-noisy) : 13'(noisy);
    assign mag_full  = noisy_abs >> noise_shift;

    assign code.sign = noisy[12];
    // clip at full code
    assign code.mag  = (mag_full > 13'd255) ? 8'hff : mag_t'(mag_full);

    always_ff @(posedge emu_clk or negedge arst_n) begin
        if (!arst_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= adder_rise;
        end
    end

    always_ff @(posedge emu_clk) begin
        if (adder_rise) begin
            sample <= code;
        end
    end

endmodule

// ==== src/adc_slice.sv ====
`timescale 1ns/10ps

module adc_slice #(
    parameter logic [15:0] seed = 16'hace1
) (
    input  logic                     emu_clk,
    input  logic                     arst_n,
    input  logic                     clk_in,
    input  adc_emu_pkg::vin_t        vin,
    input  adc_emu_pkg::slice_cfg_t  cfg,
    input  logic                     alws_on,
    input  logic                     noise_en,
    input  logic                     en_sync_in,
    output logic                     en_sync_out,
    output logic                     sample_valid,
    output adc_emu_pkg::adc_sample_t sample
);

    logic rise_pulse;
    logic fall_pulse;
    logic adder_clk;

    clk_edge_detect edge_i (
        .emu_clk    (emu_clk),
        .arst_n     (arst_n),
        .clk_in     (clk_in),
        .rise_pulse (rise_pulse),
        .fall_pulse (fall_pulse)
    );

    slice_sync sync_i (
        .emu_clk     (emu_clk),
        .arst_n      (arst_n),
        .rise_pulse  (rise_pulse),
        .fall_pulse  (fall_pulse),
        .cfg         (cfg),
        .alws_on     (alws_on),
        .en_sync_in  (en_sync_in),
        .en_sync_out (en_sync_out),
        .adder_clk   (adder_clk)
    );

    adc_quantizer #(
        .seed (seed)
    ) quant_i (
        .emu_clk      (emu_clk),
        .arst_n       (arst_n),
        .adder_clk    (adder_clk),
        .vin          (vin),
        .noise_en     (noise_en),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

endmodule

// ==== src/capture_arbiter.sv ====
`timescale 1ns/10ps

module capture_arbiter (
    input  logic                                 emu_clk,
    input  logic                                 arst_n,
    input  logic [adc_emu_pkg::num_slices-1:0]   sample_valid,
    input  adc_emu_pkg::adc_sample_t             sample [adc_emu_pkg::num_slices],
    output logic                                 wr_en,
    output adc_emu_pkg::capture_entry_t          wr_entry,
    output logic                                 overrun
);

    import adc_emu_pkg::*;

    logic [num_slices-1:0] pending;
    adc_sample_t           pend_sample [num_slices];
    slice_id_t             last_grant;
    logic                  grant_valid;
    slice_id_t             grant_id;
    logic [num_slices-1:0] grant_vec;
    logic [num_slices-1:0] accept;

    ////////////////////////////////////////
    // round-robin pick
    ////////////////////////////////////////

    // search starts one past the last winner
    always_comb begin
        slice_id_t idx;
        grant_valid = 1'b0;
        grant_id    = last_grant;
        for (int k = 1; k <= num_slices; k++) begin
            idx = last_grant + slice_id_t'(k);
            if (!grant_valid && pending[idx]) begin
                grant_valid = 1'b1;
                grant_id    = idx;
            end
        end
    end

    assign grant_vec = grant_valid ? ({{(num_slices-1){1'b0}}, 1'b1} << grant_id) : '0;

    // a slot leaving this cycle can take a new sample
    assign accept = sample_valid & (~pending | grant_vec);

    always_ff @(posedge emu_clk or negedge arst_n) begin
        if (!arst_n) begin
            pending    <= '0;
            last_grant <= '0;
            overrun    <= 1'b0;
        end else begin
            pending <= (pending & ~grant_vec) | accept;
            overrun <= overrun | (|(sample_valid & ~accept));
            if (grant_valid) begin
                last_grant <= grant_id;
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        for (int i = 0; i < num_slices; i++) begin
            if (accept[i]) begin
                pend_sample[i] <= sample[i];
            end
        end
    end

    // write goes out in the grant cycle
    assign wr_en             = grant_valid;
    assign wr_entry.slice_id = grant_id;
    assign wr_entry.sample   = pend_sample[grant_id];

endmodule

// ==== src/capture_buffer.sv ====
`timescale 1ns/10ps

module capture_buffer (
    input  logic                        emu_clk,
    input  logic                        arst_n,
    input  logic                        wr_en,
    input  adc_emu_pkg::capture_entry_t wr_entry,
    input  logic                        rd_en,
    input  adc_emu_pkg::addr_t          rd_addr,
    output adc_emu_pkg::capture_entry_t rd_data,
    output logic                        full,
    output adc_emu_pkg::count_t         count
);

    import adc_emu_pkg::*;

    capture_entry_t mem [buf_depth];
    addr_t          wr_ptr;
    logic           wr_go;

    // once full, everything else is dropped
    assign wr_go = wr_en & ~full;

    always_ff @(posedge emu_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            full   <= 1'b0;
        end else if (wr_go) begin
            wr_ptr <= wr_ptr + addr_t'(1);
            if (wr_ptr == addr_t'(buf_depth - 1)) begin
                full <= 1'b1;
            end
        end
    end

    // pointer wraps to 0 as full sets, so this reads buf_depth
    assign count = {full, wr_ptr};

    always_ff @(posedge emu_clk) begin
        if (wr_go) begin
            mem[wr_ptr] <= wr_entry;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== src/adc_emu_top.sv ====
`timescale 1ns/10ps

module adc_emu_top (
    input  logic                        emu_clk,
    input  logic                        arst_n,
    input  logic                        clk_in,
    input  adc_emu_pkg::vin_t           vin [adc_emu_pkg::num_slices],
    input  adc_emu_pkg::slice_cfg_t     cfg [adc_emu_pkg::num_slices],
    input  logic                        alws_on,
    input  logic                        noise_en,
    input  logic                        en_sync_in,
    input  logic                        rd_en,
    input  adc_emu_pkg::addr_t          rd_addr,
    output logic                        en_sync_out,
    output adc_emu_pkg::capture_entry_t rd_data,
    output logic                        full,
    output adc_emu_pkg::count_t         count,
    output logic                        overrun
);

    import adc_emu_pkg::*;

    logic [num_slices:0]   en_chain;
    logic [num_slices-1:0] sample_valid;
    adc_sample_t           sample [num_slices];
    logic                  wr_en;
    capture_entry_t        wr_entry;

    ////////////////////////////////////////
    // slice chain
    ////////////////////////////////////////

    assign en_chain[0] = en_sync_in;
    assign en_sync_out = en_chain[num_slices];

    for (genvar i = 0; i < num_slices; i++) begin : slice_g
        adc_slice #(
            .seed (noise_seeds[i])
        ) slice_i (
            .emu_clk      (emu_clk),
            .arst_n       (arst_n),
            .clk_in       (clk_in),
            .vin          (vin[i]),
            .cfg          (cfg[i]),
            .alws_on      (alws_on),
            .noise_en     (noise_en),
            .en_sync_in   (en_chain[i]),
            .en_sync_out  (en_chain[i+1]),
            .sample_valid (sample_valid[i]),
            .sample       (sample[i])
        );
    end

    ////////////////////////////////////////
    // capture path
    ////////////////////////////////////////

    capture_arbiter arb_i (
        .emu_clk      (emu_clk),
        .arst_n       (arst_n),
        .sample_valid (sample_valid),
        .sample       (sample),
        .wr_en        (wr_en),
        .wr_entry     (wr_entry),
        .overrun      (overrun)
    );

    capture_buffer buf_i (
        .emu_clk  (emu_clk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .wr_entry (wr_entry),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .full     (full),
        .count    (count)
    );

endmodule

// ==== test/tb_adc_emu.sv ====
`timescale 1ns/10ps

module tb_adc_emu;

    import adc_emu_pkg::*;

    localparam int clk_period    = 100;
    localparam int half_clk_in   = 8;
    localparam int clk_in_cycles = 2 * half_clk_in;
    // one divider wraps every 4 clk_in periods
    localparam int sample_cycles = 4 * clk_in_cycles;
    localparam int wait_limit    = 8 * sample_cycles;
    localparam int n_quant       = 12;
    localparam int n_inter       = 12;
    localparam int n_noise       = 16;

    // expected length of each test in emu_clk cycles
    localparam int reset_len     = 20;
    localparam int quant_len     = n_quant * sample_cycles + 8 * clk_in_cycles;
    localparam int inter_len     = 40 * clk_in_cycles;
    localparam int alws_len      = 30 * clk_in_cycles;
    localparam int full_len      = (buf_depth + 40) * clk_in_cycles;
    localparam int noise_len     = (n_noise + 16) * clk_in_cycles;
    localparam int margin_len    = 1000;
    localparam int watchdog_len  = reset_len + quant_len + inter_len + alws_len
                                 + full_len + noise_len + margin_len;

    logic           emu_clk = 1'b0;
    logic           arst_n;
    logic           clk_in;
    vin_t           vin [num_slices];
    slice_cfg_t     cfg [num_slices];
    logic           alws_on;
    logic           noise_en;
    logic           en_sync_in;
    logic           rd_en;
    addr_t          rd_addr;
    logic           en_sync_out;
    capture_entry_t rd_data;
    logic           full;
    count_t         count;
    logic           overrun;

    int             error_count;
    string          test_name;

    adc_emu_top dut_i (
        .emu_clk     (emu_clk),
        .arst_n      (arst_n),
        .clk_in      (clk_in),
        .vin         (vin),
        .cfg         (cfg),
        .alws_on     (alws_on),
        .noise_en    (noise_en),
        .en_sync_in  (en_sync_in),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .en_sync_out (en_sync_out),
        .rd_data     (rd_data),
        .full        (full),
        .count       (count),
        .overrun     (overrun)
    );

    always #(clk_period / 2) emu_clk = ~emu_clk;

    // slow converter clock driven on falling emu_clk like the other inputs
    initial begin
        clk_in = 1'b0;
        forever begin
            repeat (half_clk_in) @(negedge emu_clk);
            clk_in = ~clk_in;
        end
    end

    initial begin
        #(watchdog_len * clk_period);
        fail_run("watchdog timeout: the tests ran longer than their expected length");
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string what, input int expected, input int actual);
        if (expected != actual) begin
            error_count++;
            fail_run($sformatf("error: %s %s expected %0d actual %0d",
                               test_name, what, expected, actual));
        end
    endtask

    // sign/magnitude code of a noiseless input
    function automatic int quant_mag(input int v);
        int a;
        a = (v < 0) ? -v : v;
        a = a >> noise_shift;
        if (a > 255) begin
            a = 255;
        end
        return a;
    endfunction

    function automatic int quant_sign(input int v);
        return (v < 0) ? 1 : 0;
    endfunction

    task automatic apply_reset;
        @(negedge emu_clk);
        arst_n     = 1'b0;
        en_sync_in = 1'b0;
        alws_on    = 1'b0;
        noise_en   = 1'b0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        for (int k = 0; k < num_slices; k++) begin
            cfg[k] = '0;
            vin[k] = '0;
        end
        repeat (8) @(negedge emu_clk);
        arst_n = 1'b1;
    endtask

    task automatic configure(input logic [num_slices-1:0] en_mask,
                             input logic [num_slices-1:0][1:0] inits);
        for (int k = 0; k < num_slices; k++) begin
            cfg[k].en_slice = en_mask[k];
            cfg[k].init     = inits[k];
        end
    endtask

    task automatic randomize_inputs;
        for (int k = 0; k < num_slices; k++) begin
            vin[k] = vin_t'($urandom_range(0, 4095));
        end
    endtask

    task automatic wait_count(input int target, input int limit);
        int n;
        n = 0;
        while (int'(count) < target) begin
            @(negedge emu_clk);
            n++;
            if (n > limit) begin
                fail_run($sformatf("%s: count did not reach %0d within %0d cycles",
                                   test_name, target, limit));
            end
        end
    endtask

    // read data shows up on the cycle after rd_en
    task automatic read_entry(input int addr, output capture_entry_t e);
        @(negedge emu_clk);
        rd_en   = 1'b1;
        rd_addr = addr_t'(addr);
        @(negedge emu_clk);
        rd_en = 1'b0;
        e     = rd_data;
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic test_reset;
        test_name = "reset";
        apply_reset();
        @(negedge emu_clk);
        check("count", 0, int'(count));
        check("full", 0, int'(full));
        check("overrun", 0, int'(overrun));
        check("en_sync_out", 0, int'(en_sync_out));
    endtask

    task automatic test_quant;
        int             exp_v [n_quant];
        capture_entry_t e;
        test_name = "quant";
        apply_reset();
        configure(4'b0001, '0);
        vin[0]   = vin_t'($urandom_range(0, 4095));
        exp_v[0] = int'(vin[0]);
        en_sync_in = 1'b1;
        wait_count(1, wait_limit);
        // next sample is a full divider period away
        for (int i = 1; i < n_quant; i++) begin
            vin[0]   = vin_t'($urandom_range(0, 4095));
            exp_v[i] = int'(vin[0]);
            wait_count(i + 1, wait_limit);
        end
        for (int i = 0; i < n_quant; i++) begin
            read_entry(i, e);
            check($sformatf("entry %0d slice id", i), 0, int'(e.slice_id));
            check($sformatf("entry %0d sign", i), quant_sign(exp_v[i]), int'(e.sample.sign));
            check($sformatf("entry %0d mag", i), quant_mag(exp_v[i]), int'(e.sample.mag));
        end
    endtask

    task automatic test_interleave;
        int             first_fall [num_slices];
        int             exp_id [$];
        int             last;
        int             id;
        int             f;
        int             n;
        int             v;
        capture_entry_t e;
        test_name = "interleave";
        apply_reset();
        randomize_inputs();
        configure(4'b1111, {2'd0, 2'd1, 2'd2, 2'd3});
        en_sync_in = 1'b1;
        // slice k sees the enable k clk_in periods late, then needs 4 - init falls
        for (int k = 0; k < num_slices; k++) begin
            first_fall[k] = k + 4 - int'(cfg[k].init);
        end
        last = 0;
        f    = 0;
        while (exp_id.size() < n_inter) begin
            for (int j = 1; j <= num_slices; j++) begin
                id = (last + j) % num_slices;
                if (f >= first_fall[id] && (f - first_fall[id]) % 4 == 0) begin
                    exp_id.push_back(id);
                end
            end
            if (exp_id.size() > 0) begin
                last = exp_id[$];
            end
            f++;
        end
        n = 0;
        while (en_sync_out !== 1'b1) begin
            @(negedge emu_clk);
            n++;
            if (n > wait_limit) begin
                fail_run("interleave: en_sync_out never went high after the chain was enabled");
            end
        end
        wait_count(n_inter, wait_limit);
        for (int i = 0; i < n_inter; i++) begin
            read_entry(i, e);
            check($sformatf("entry %0d slice id", i), exp_id[i], int'(e.slice_id));
            v = int'(vin[e.slice_id]);
            check($sformatf("entry %0d sign", i), quant_sign(v), int'(e.sample.sign));
            check($sformatf("entry %0d mag", i), quant_mag(v), int'(e.sample.mag));
        end
    endtask

    task automatic test_alws_on;
        int held;
        test_name = "alws_on";
        apply_reset();
        randomize_inputs();
        configure(4'b1111, '0);
        en_sync_in = 1'b1;
        wait_count(2, wait_limit);
        alws_on = 1'b1;
        // let a sample already in flight drain
        repeat (8) @(negedge emu_clk);
        held = int'(count);
        repeat (8 * clk_in_cycles) @(negedge emu_clk);
        check("count while held", held, int'(count));
        alws_on = 1'b0;
        wait_count(held + 1, wait_limit);
    endtask

    task automatic test_full;
        capture_entry_t snap [buf_depth];
        capture_entry_t e;
        test_name = "full";
        apply_reset();
        randomize_inputs();
        configure(4'b1111, '0);
        en_sync_in = 1'b1;
        wait_count(buf_depth, (buf_depth + 16) * clk_in_cycles);
        check("full at depth", 1, int'(full));
        // later samples carry new codes, so a stray write would show
        randomize_inputs();
        for (int i = 0; i < buf_depth; i++) begin
            read_entry(i, snap[i]);
        end
        repeat (4 * sample_cycles) @(negedge emu_clk);
        check("count after full", buf_depth, int'(count));
        check("full held", 1, int'(full));
        check("overrun", 0, int'(overrun));
        for (int i = 0; i < buf_depth; i++) begin
            read_entry(i, e);
            check($sformatf("entry %0d unchanged", i), int'(snap[i]), int'(e));
        end
    endtask

    task automatic test_noise;
        capture_entry_t e;
        int             v;
        int             exp_mag;
        int             diff;
        test_name = "noise";
        apply_reset();
        vin[0] = vin_t'(1000);
        vin[1] = vin_t'(-523);
        vin[2] = vin_t'(20);
        vin[3] = vin_t'(-9);
        noise_en = 1'b1;
        configure(4'b1111, '0);
        en_sync_in = 1'b1;
        wait_count(n_noise, wait_limit);
        for (int i = 0; i < n_noise; i++) begin
            read_entry(i, e);
            v       = int'(vin[e.slice_id]);
            exp_mag = quant_mag(v);
            diff    = exp_mag - int'(e.sample.mag);
            // noise is at most one lsb of the shifted code
            if (diff > 1 || diff < -1) begin
                check($sformatf("entry %0d mag", i), exp_mag, int'(e.sample.mag));
            end
            if (v > 16 || v < -16) begin
                check($sformatf("entry %0d sign", i), quant_sign(v), int'(e.sample.sign));
            end
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        error_count = 0;
        test_name   = "init";
        void'($urandom(93159));
        arst_n     = 1'b0;
        en_sync_in = 1'b0;
        alws_on    = 1'b0;
        noise_en   = 1'b0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        for (int k = 0; k < num_slices; k++) begin
            cfg[k] = '0;
            vin[k] = '0;
        end

        test_reset();
        test_quant();
        test_interleave();
        test_alws_on();
        test_full();
        test_noise();

        if (error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_run("checks failed during the run");
        end
    end

endmodule

// ==== sources.f ====
src/adc_emu_pkg.sv
src/clk_edge_detect.sv
src/slice_sync.sv
src/adc_quantizer.sv
src/adc_slice.sv
src/capture_arbiter.sv
src/capture_buffer.sv
src/adc_emu_top.sv
test/tb_adc_emu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ADC emulation testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
    --top-module tb_adc_emu -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_adc_emu > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
